/* Bender.yml */
package:
  name: disp_select

sources:
  - include_dirs:
      - .
    files:
      - disp_types_pkg.sv
      - disp_regs_pkg.sv
      - find_max.sv
      - disp_result_filter.sv
      - disp_apb_regs.sv
      - disp_select_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - disp_select_assert.sv
      - disp_select_tb.sv

/* disp_apb_regs.sv */
`timescale 1ns/1ps
`include "disp_defines.svh"

module disp_apb_regs
(
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        psel,
    input  logic                        penable,
    input  logic                        pwrite,
    input  logic [`DISP_APB_AW-1:0]     paddr,
    input  logic [`DISP_APB_DW-1:0]     pwdata,
    output logic [`DISP_APB_DW-1:0]     prdata,
    output logic                        pready,
    output logic                        pslverr,
    output logic                        enable,
    output disp_types_pkg::out_score_t  threshold,
    output logic                        clear,
    input  disp_types_pkg::count_t      match_count,
    input  disp_types_pkg::count_t      reject_count,
    input  disp_types_pkg::out_score_t  last_score,
    input  disp_types_pkg::index_t      last_index,
    input  logic                        last_match
);

    // phase the bus was in during the previous cycle.
    disp_regs_pkg::apb_state_t state;

    logic                    access;
    logic                    mapped;
    logic [`DISP_APB_DW-1:0] rdata;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= disp_regs_pkg::IDLE;
        end
        else
        begin
            case (state)
                disp_regs_pkg::SETUP:
                begin
                    if (psel && penable)
                        state <= disp_regs_pkg::ACCESS;
                    else if (psel)
                        state <= disp_regs_pkg::SETUP;
                    else
                        state <= disp_regs_pkg::IDLE;
                end
                default:
                begin
                    if (psel && !penable)
                        state <= disp_regs_pkg::SETUP;
                    else
                        state <= disp_regs_pkg::IDLE;
                end
            endcase
        end
    end

    // an access phase only counts when it follows a setup phase.
    assign access  = (state == disp_regs_pkg::SETUP) && psel && penable;
    assign pready  = 1'b1;
    assign pslverr = access && !mapped;
    assign prdata  = access ? rdata : '0;

    always_comb
    begin
        rdata  = '0;
        mapped = 1'b1;
        case (paddr)
            disp_regs_pkg::REG_CTRL:       rdata[disp_regs_pkg::CTRL_ENABLE_BIT] = enable;
            disp_regs_pkg::REG_THRESH:     rdata[`DISP_OUT_W-1:0] = threshold;
            disp_regs_pkg::REG_MATCH_CNT:  rdata[`DISP_CNT_W-1:0] = match_count;
            disp_regs_pkg::REG_REJECT_CNT: rdata[`DISP_CNT_W-1:0] = reject_count;
            disp_regs_pkg::REG_LAST:
            begin
                rdata[16]                 = last_match;
                rdata[8 +: `DISP_OUT_W]   = last_score;
                rdata[`DISP_INDEX_W-1:0]  = last_index;
            end
            default:                       mapped = 1'b0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            enable    <= 1'b0;
            threshold <= '0;
            clear     <= 1'b0;
        end
        else
        begin
            clear <= 1'b0;
            if (access && pwrite)
            begin
                case (paddr)
                    disp_regs_pkg::REG_CTRL:
                    begin
                        enable <= pwdata[disp_regs_pkg::CTRL_ENABLE_BIT];
                        clear  <= pwdata[disp_regs_pkg::CTRL_CLEAR_BIT];
                    end
                    disp_regs_pkg::REG_THRESH: threshold <= pwdata[`DISP_OUT_W-1:0];
                    // counters and last result are read only.
                    default: ;
                endcase
            end
        end
    end

endmodule

/* disp_defines.svh */
`ifndef DISP_DEFINES_SVH
`define DISP_DEFINES_SVH

// number of disparity candidates per pixel.
`define DISP_NUM_CAND 21

// raw correlation score and the reported upper bits of the winner.
`define DISP_SCORE_W 11
`define DISP_OUT_W 8

`define DISP_INDEX_W 5
`define DISP_CNT_W 16

// register bus.
`define DISP_APB_AW 8
`define DISP_APB_DW 32

`endif

/* disp_regs_pkg.sv */
`include "disp_defines.svh"

package disp_regs_pkg;

    // register offsets.
    localparam logic [`DISP_APB_AW-1:0] REG_CTRL       = 'h00;
    localparam logic [`DISP_APB_AW-1:0] REG_THRESH     = 'h04;
    localparam logic [`DISP_APB_AW-1:0] REG_MATCH_CNT  = 'h08;
    localparam logic [`DISP_APB_AW-1:0] REG_REJECT_CNT = 'h0C;
    localparam logic [`DISP_APB_AW-1:0] REG_LAST       = 'h10;

    // control register fields.
    localparam int CTRL_ENABLE_BIT = 0;
    localparam int CTRL_CLEAR_BIT  = 1;

    // bus phase seen by the slave.
    typedef enum logic [1:0]
    {
        IDLE,
        SETUP,
        ACCESS
    } apb_state_t;

endpackage

/* disp_result_filter.sv */
`timescale 1ns/1ps

module disp_result_filter
(
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        max_valid,
    input  disp_types_pkg::out_score_t  max_score,
    input  disp_types_pkg::index_t      max_index,
    input  logic                        enable,
    input  disp_types_pkg::out_score_t  threshold,
    input  logic                        clear,
    output logic                        result_valid,
    output disp_types_pkg::out_score_t  result_score,
    output disp_types_pkg::index_t      result_index,
    output logic                        result_match,
    output disp_types_pkg::count_t      match_count,
    output disp_types_pkg::count_t      reject_count,
    output disp_types_pkg::out_score_t  last_score,
    output disp_types_pkg::index_t     last_index,
    output logic                        last_match
);

    logic accept;
    logic hit;

    // results arriving while disabled are dropped.
    assign accept = max_valid && enable;
    assign hit    = (max_score >= threshold);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            result_valid <= 1'b0;
            last_score   <= '0;
            last_index   <= '0;
            last_match   <= 1'b0;
        end
        else
        begin
            result_valid <= accept;
            if (accept)
            begin
                last_score <= max_score;
                last_index <= max_index;
                last_match <= hit;
            end
        end
    end

    // clear wins over a result in the same cycle. counters stick at all ones.
    always_ff @(posedge clk)
    begin
        if (reset || clear)
        begin
            match_count  <= '0;
            reject_count <= '0;
        end
        else if (accept)
        begin
            if (hit && (match_count != '1))
                match_count <= match_count + 1'b1;
            if (!hit && (reject_count != '1))
                reject_count <= reject_count + 1'b1;
        end
    end

    // the stream shows the result just captured.
    assign result_score = last_score;
    assign result_index = last_index;
    assign result_match = last_match;

endmodule

/* disp_select_assert.sv */
`timescale 1ns/1ps

module disp_select_assert
(
    input logic clk,
    input logic reset,
    input logic score_valid,
    input logic enable,
    input logic result_valid,
    input logic psel,
    input logic penable,
    input logic pslverr
);

    // number of failed assertions so far.
    int unsigned fail_count = 0;

    // enable is looked at when the winner reaches the filter.
    property result_latency;
        @(posedge clk) disable iff (reset)
        (score_valid && enable) ##6 enable |=> result_valid;
    endproperty

    property result_has_source;
        @(posedge clk) disable iff (reset)
        result_valid |-> $past(score_valid, 7);
    endproperty

    // an access phase is the cycle right after a setup phase.
    property slverr_in_access;
        @(posedge clk) disable iff (reset)
        pslverr |-> (psel && penable && $past(psel && !penable));
    endproperty

    property quiet_in_reset;
        @(posedge clk) reset |=> !result_valid;
    endproperty

    a_result_latency: assert property (result_latency)
        else
        begin
            fail_count++;
            $error("result_valid missing seven cycles after score_valid");
        end
    a_result_has_source: assert property (result_has_source)
        else
        begin
            fail_count++;
            $error("result_valid without score_valid seven cycles earlier");
        end
    a_slverr_in_access: assert property (slverr_in_access)
        else
        begin
            fail_count++;
            $error("pslverr outside an access phase");
        end
    a_quiet_in_reset: assert property (quiet_in_reset)
        else
        begin
            fail_count++;
            $error("result_valid high during reset");
        end

endmodule

bind disp_select_top disp_select_assert u_assert
(
    .clk          (clk),
    .reset        (reset),
    .score_valid  (score_valid),
    .enable       (enable),
    .result_valid (result_valid),
    .psel         (psel),
    .penable      (penable),
    .pslverr      (pslverr)
);

/* disp_select_tb.sv */
`timescale 1ns/1ps
`include "disp_defines.svh"

module disp_select_tb;

    localparam int BUS_W   = `DISP_NUM_CAND * `DISP_SCORE_W;
    localparam int SW      = `DISP_SCORE_W;
    localparam int TIMEOUT = 200;

    logic                        clk;
    logic                        reset;
    logic                        score_valid;
    logic [BUS_W-1:0]            scores;
    logic                        result_valid;
    disp_types_pkg::index_t      result_index;
    disp_types_pkg::out_score_t  result_score;
    logic                        result_match;
    logic                        psel;
    logic                        penable;
    logic                        pwrite;
    logic [`DISP_APB_AW-1:0]     paddr;
    logic [`DISP_APB_DW-1:0]     pwdata;
    logic [`DISP_APB_DW-1:0]     prdata;
    logic                        pready;
    logic                        pslverr;

    string                       test_name;
    int                          cycle;
    logic                        en_model;
    disp_types_pkg::out_score_t  thr_model;
    disp_types_pkg::count_t      match_model;
    disp_types_pkg::count_t      reject_model;
    logic [31:0]                 last_model;

    // expected results in arrival order.
    int q_index[$];
    int q_score[$];
    int q_match[$];
    int q_due[$];

    disp_select_top u_dut
    (
        .clk          (clk),
        .reset        (reset),
        .score_valid  (score_valid),
        .scores       (scores),
        .result_valid (result_valid),
        .result_index (result_index),
        .result_score (result_score),
        .result_match (result_match),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .paddr        (paddr),
        .pwdata       (pwdata),
        .prdata       (prdata),
        .pready       (pready),
        .pslverr      (pslverr)
    );

    initial
    begin
        clk = 1'b0;
    end

    always #50 clk = ~clk;

    always @(posedge clk)
    begin
        cycle <= cycle + 1;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1, "simulation stopped");
    endtask

    always @(u_dut.u_assert.fail_count)
    begin
        if (u_dut.u_assert.fail_count != 0)
        begin
            abort_run("a bound assertion failed");
        end
    end

    task automatic check(input string what, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual)
        begin
            $display("[ERROR] %s %s: expected 0x%0h, actual 0x%0h",
                     test_name, what, expected, actual);
            abort_run("value mismatch");
        end
    endtask

    task automatic apb_xfer(input logic write, input logic [`DISP_APB_AW-1:0] addr,
                            input logic [`DISP_APB_DW-1:0] wdata,
                            output logic [`DISP_APB_DW-1:0] rdata, output logic err);
        int waits;
        waits = 0;
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= write;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        while (!pready)
        begin
            if (waits == TIMEOUT)
            begin
                abort_run("timeout waiting for pready");
            end
            waits++;
            @(negedge clk);
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic apb_write(input logic [`DISP_APB_AW-1:0] addr, input logic [31:0] data);
        logic [31:0] rdata;
        logic        err;
        apb_xfer(1'b1, addr, data, rdata, err);
        check("write pslverr", 0, err);
    endtask

    task automatic read_expect(input string what, input logic [`DISP_APB_AW-1:0] addr,
                               input logic [31:0] expected);
        logic [31:0] rdata;
        logic        err;
        apb_xfer(1'b0, addr, '0, rdata, err);
        check({what, " pslverr"}, 0, err);
        check(what, expected, rdata);
    endtask

    function automatic logic [BUS_W-1:0] random_scores(input int unsigned limit);
        logic [BUS_W-1:0] s;
        for (int k = 0; k < `DISP_NUM_CAND; k++)
        begin
            s[k*SW +: SW] = SW'($urandom % limit);
        end
        return s;
    endfunction

    // reference model: largest score wins, the highest index among equal maxima.
    task automatic send_scores(input logic [BUS_W-1:0] s);
        disp_types_pkg::score_t     best;
        disp_types_pkg::out_score_t top;
        int                         idx;
        logic                       hit;
        @(posedge clk);
        score_valid <= 1'b1;
        scores      <= s;
        best = s[0 +: SW];
        idx  = 0;
        for (int k = 1; k < `DISP_NUM_CAND; k++)
        begin
            if (s[k*SW +: SW] >= best)
            begin
                best = s[k*SW +: SW];
                idx  = k;
            end
        end
        top = best[SW-1 -: `DISP_OUT_W];
        hit = (top >= thr_model);
        if (en_model)
        begin
            q_index.push_back(idx);
            q_score.push_back(top);
            q_match.push_back(hit);
            // seen at the negedge after the seventh edge past the drive.
            q_due.push_back(cycle + 8);
            if (hit && match_model != '1)
                match_model++;
            if (!hit && reject_model != '1)
                reject_model++;
            last_model        = '0;
            last_model[16]    = hit;
            last_model[15:8]  = top;
            last_model[4:0]   = idx[4:0];
        end
    endtask

    task automatic stream_idle();
        @(posedge clk);
        score_valid <= 1'b0;
    endtask

    task automatic wait_drain();
        int waits;
        waits = 0;
        while (q_due.size() != 0)
        begin
            if (waits == TIMEOUT)
            begin
                abort_run("timeout waiting for expected results");
            end
            waits++;
            @(posedge clk);
        end
    endtask

    always @(negedge clk)
    begin
        if (!reset && result_valid)
        begin
            if (q_due.size() == 0)
            begin
                abort_run("result appeared with no matching input");
            end
            else
            begin
                check("index", q_index.pop_front(), result_index);
                check("score", q_score.pop_front(), result_score);
                check("match", q_match.pop_front(), result_match);
                check("arrival cycle", q_due.pop_front(), cycle);
            end
        end
    end

    task automatic test_registers();
        logic [31:0] rdata;
        logic        err;
        test_name = "registers";
        read_expect("ctrl reset", disp_regs_pkg::REG_CTRL, 0);
        read_expect("thresh reset", disp_regs_pkg::REG_THRESH, 0);
        read_expect("match reset", disp_regs_pkg::REG_MATCH_CNT, 0);
        read_expect("reject reset", disp_regs_pkg::REG_REJECT_CNT, 0);
        read_expect("last reset", disp_regs_pkg::REG_LAST, 0);
        apb_write(disp_regs_pkg::REG_THRESH, 32'h5A);
        thr_model = 8'h5A;
        read_expect("thresh", disp_regs_pkg::REG_THRESH, 32'h5A);
        apb_write(disp_regs_pkg::REG_CTRL, 32'h1);
        en_model = 1'b1;
        read_expect("ctrl", disp_regs_pkg::REG_CTRL, 32'h1);
        // read-only register ignores the write.
        apb_write(disp_regs_pkg::REG_MATCH_CNT, 32'h1234);
        read_expect("match after write", disp_regs_pkg::REG_MATCH_CNT, 0);
        apb_xfer(1'b0, 8'h14, '0, rdata, err);
        check("unmapped pslverr", 1, err);
    endtask

    task automatic test_winner();
        logic [BUS_W-1:0] s;
        test_name = "winner";
        for (int p = 0; p < `DISP_NUM_CAND; p++)
        begin
            s = random_scores(1024);
            s[p*SW +: SW] = SW'(1024 + ($urandom % 1024));
            send_scores(s);
            stream_idle();
            wait_drain();
        end
    endtask

    task automatic tie_case(input int a, input int b, input int c);
        logic [BUS_W-1:0] s;
        s = random_scores(1024);
        s[a*SW +: SW] = 11'd1500;
        s[b*SW +: SW] = 11'd1500;
        s[c*SW +: SW] = 11'd1500;
        send_scores(s);
        stream_idle();
        wait_drain();
    endtask

    task automatic test_ties();
        logic [BUS_W-1:0] s;
        test_name = "ties";
        tie_case(3, 9, 15);
        tie_case(0, 0, 20);
        tie_case(18, 19, 19);
        tie_case(4, 10, 11);
        for (int k = 0; k < `DISP_NUM_CAND; k++)
        begin
            s[k*SW +: SW] = 11'd700;
        end
        send_scores(s);
        stream_idle();
        wait_drain();
    endtask

    task automatic test_streaming();
        test_name = "streaming";
        for (int n = 0; n < 10; n++)
        begin
            send_scores(random_scores(2048));
        end
        stream_idle();
        wait_drain();
    endtask

    task automatic test_threshold();
        logic [BUS_W-1:0] s;
        int               peaks [5];
        test_name = "threshold";
        peaks = '{11'h400, 11'h3F8, 11'h7FF, 11'h100, 11'h408};
        apb_write(disp_regs_pkg::REG_THRESH, 32'h80);
        thr_model = 8'h80;
        apb_write(disp_regs_pkg::REG_CTRL, 32'h3);
        match_model  = '0;
        reject_model = '0;
        read_expect("ctrl clear bit", disp_regs_pkg::REG_CTRL, 32'h1);
        read_expect("match cleared", disp_regs_pkg::REG_MATCH_CNT, 0);
        for (int n = 0; n < 5; n++)
        begin
            s = random_scores(peaks[n]);
            s[(n*4)*SW +: SW] = SW'(peaks[n]);
            send_scores(s);
        end
        stream_idle();
        wait_drain();
        read_expect("match count", disp_regs_pkg::REG_MATCH_CNT, match_model);
        read_expect("reject count", disp_regs_pkg::REG_REJECT_CNT, reject_model);
        read_expect("last result", disp_regs_pkg::REG_LAST, last_model);
        apb_write(disp_regs_pkg::REG_CTRL, 32'h3);
        match_model  = '0;
        reject_model = '0;
        read_expect("match after clear", disp_regs_pkg::REG_MATCH_CNT, 0);
        read_expect("reject after clear", disp_regs_pkg::REG_REJECT_CNT, 0);
    endtask

    task automatic test_disable();
        test_name = "disable";
        apb_write(disp_regs_pkg::REG_CTRL, 32'h0);
        en_model = 1'b0;
        for (int n = 0; n < 3; n++)
        begin
            send_scores(random_scores(2048));
        end
        stream_idle();
        // the monitor flags any result seen in this window.
        for (int n = 0; n < 12; n++)
        begin
            @(posedge clk);
        end
        read_expect("match disabled", disp_regs_pkg::REG_MATCH_CNT, match_model);
        read_expect("reject disabled", disp_regs_pkg::REG_REJECT_CNT, reject_model);
        apb_write(disp_regs_pkg::REG_CTRL, 32'h1);
        en_model = 1'b1;
        send_scores(random_scores(2048));
        send_scores(random_scores(2048));
        stream_idle();
        wait_drain();
        read_expect("match enabled", disp_regs_pkg::REG_MATCH_CNT, match_model);
        read_expect("reject enabled", disp_regs_pkg::REG_REJECT_CNT, reject_model);
        read_expect("last enabled", disp_regs_pkg::REG_LAST, last_model);
    endtask

    initial
    begin
        void'($urandom(32'hdf673a34));
        cycle        = 0;
        en_model     = 1'b0;
        thr_model    = '0;
        match_model  = '0;
        reject_model = '0;
        last_model   = '0;
        test_name    = "reset";
        reset        = 1'b1;
        score_valid  = 1'b0;
        scores       = '0;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        paddr        = '0;
        pwdata       = '0;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        test_registers();
        test_winner();
        test_ties();
        test_streaming();
        test_threshold();
        test_disable();
        // let the assertions of the last edge settle.
        @(negedge clk);
        $display("Test passed");
        $finish;
    end

endmodule

/* disp_select_top.sv */
`timescale 1ns/1ps
`include "disp_defines.svh"

module disp_select_top
(
    input  logic                                       clk,
    input  logic                                       reset,
    input  logic                                       score_valid,
    input  logic [`DISP_NUM_CAND*`DISP_SCORE_W-1:0]    scores,
    output logic                                       result_valid,
    output disp_types_pkg::index_t                     result_index,
    output disp_types_pkg::out_score_t                 result_score,
    output logic                                       result_match,
    input  logic                                       psel,
    input  logic                                       penable,
    input  logic                                       pwrite,
    input  logic [`DISP_APB_AW-1:0]                    paddr,
    input  logic [`DISP_APB_DW-1:0]                    pwdata,
    output logic [`DISP_APB_DW-1:0]                    prdata,
    output logic                                       pready,
    output logic                                       pslverr
);

    logic                        max_valid;
    disp_types_pkg::out_score_t  max_score;
    disp_types_pkg::index_t      max_index;

    logic                        enable;
    disp_types_pkg::out_score_t  threshold;
    logic                        clear;

    disp_types_pkg::count_t      match_count;
    disp_types_pkg::count_t      reject_count;
    disp_types_pkg::out_score_t  last_score;
    disp_types_pkg::index_t      last_index;
    logic                        last_match;

    find_max u_find_max
    (
        .clk         (clk),
        .reset       (reset),
        .score_valid (score_valid),
        .scores      (scores),
        .max_valid   (max_valid),
        .max_score   (max_score),
        .max_index   (max_index)
    );

    disp_result_filter u_filter
    (
        .clk          (clk),
        .reset        (reset),
        .max_valid    (max_valid),
        .max_score    (max_score),
        .max_index    (max_index),
        .enable       (enable),
        .threshold    (threshold),
        .clear        (clear),
        .result_valid (result_valid),
        .result_score (result_score),
        .result_index (result_index),
        .result_match (result_match),
        .match_count  (match_count),
        .reject_count (reject_count),
        .last_score   (last_score),
        .last_index   (last_index),
        .last_match   (last_match)
    );

    disp_apb_regs u_regs
    (
        .clk          (clk),
        .reset        (reset),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .paddr        (paddr),
        .pwdata       (pwdata),
        .prdata       (prdata),
        .pready       (pready),
        .pslverr      (pslverr),
        .enable       (enable),
        .threshold    (threshold),
        .clear        (clear),
        .match_count  (match_count),
        .reject_count (reject_count),
        .last_score   (last_score),
        .last_index   (last_index),
        .last_match   (last_match)
    );

endmodule

/* disp_types_pkg.sv */
`include "disp_defines.svh"

package disp_types_pkg;

    // one correlation score as produced by the correlation engine.
    typedef logic [`DISP_SCORE_W-1:0] score_t;

    // upper bits of the winning score, as reported on the result stream.
    typedef logic [`DISP_OUT_W-1:0] out_score_t;

    // disparity index of a candidate.
    typedef logic [`DISP_INDEX_W-1:0] index_t;

    // match and reject counters.
    typedef logic [`DISP_CNT_W-1:0] count_t;

endpackage

/* find_max.sv */
`timescale 1ns/1ps
`include "disp_defines.svh"

module find_max
(
    input  logic                                       clk,
    input  logic                                       reset,
    input  logic                                       score_valid,
    input  logic [`DISP_NUM_CAND*`DISP_SCORE_W-1:0]    scores,
    output logic                                       max_valid,
    output disp_types_pkg::out_score_t                 max_score,
    output disp_types_pkg::index_t                     max_index
);

    localparam int LEVELS = 5;
    localparam int L0_N = `DISP_NUM_CAND;
    localparam int L1_N = (L0_N + 1) / 2;
    localparam int L2_N = (L1_N + 1) / 2;
    localparam int L3_N = (L2_N + 1) / 2;
    localparam int L4_N = (L3_N + 1) / 2;

    disp_types_pkg::score_t cand [L0_N];

    disp_types_pkg::score_t l1_score [L1_N];
    disp_types_pkg::index_t l1_index [L1_N];
    disp_types_pkg::score_t l2_score [L2_N];
    disp_types_pkg::index_t l2_index [L2_N];
    disp_types_pkg::score_t l3_score [L3_N];
    disp_types_pkg::index_t l3_index [L3_N];
    disp_types_pkg::score_t l4_score [L4_N];
    disp_types_pkg::index_t l4_index [L4_N];
    disp_types_pkg::score_t l5_score;
    disp_types_pkg::index_t l5_index;

    logic [LEVELS-1:0] valid_pipe;

    always_comb
    begin
        for (int k = 0; k < L0_N; k++)
        begin
            cand[k] = scores[k*`DISP_SCORE_W +: `DISP_SCORE_W];
        end
    end

    // each compare keeps the right operand unless the left is strictly
    // greater, so ties go to the higher index.
    always_ff @(posedge clk)
    begin
        for (int i = 0; i < L0_N / 2; i++)
        begin
            if (cand[2*i] > cand[2*i+1])
            begin
                l1_score[i] <= cand[2*i];
                l1_index[i] <= disp_types_pkg::index_t'(2*i);
            end
            else
            begin
                l1_score[i] <= cand[2*i+1];
                l1_index[i] <= disp_types_pkg::index_t'(2*i+1);
            end
        end
        // last candidate has no partner here.
        l1_score[L1_N-1] <= cand[L0_N-1];
        l1_index[L1_N-1] <= disp_types_pkg::index_t'(L0_N-1);

        for (int i = 0; i < L1_N / 2; i++)
        begin
            if (l1_score[2*i] > l1_score[2*i+1])
            begin
                l2_score[i] <= l1_score[2*i];
                l2_index[i] <= l1_index[2*i];
            end
            else
            begin
                l2_score[i] <= l1_score[2*i+1];
                l2_index[i] <= l1_index[2*i+1];
            end
        end
        l2_score[L2_N-1] <= l1_score[L1_N-1];
        l2_index[L2_N-1] <= l1_index[L1_N-1];

        for (int i = 0; i < L3_N; i++)
        begin
            if (l2_score[2*i] > l2_score[2*i+1])
            begin
                l3_score[i] <= l2_score[2*i];
                l3_index[i] <= l2_index[2*i];
            end
            else
            begin
                l3_score[i] <= l2_score[2*i+1];
                l3_index[i] <= l2_index[2*i+1];
            end
        end

        if (l3_score[0] > l3_score[1])
        begin
            l4_score[0] <= l3_score[0];
            l4_index[0] <= l3_index[0];
        end
        else
        begin
            l4_score[0] <= l3_score[1];
            l4_index[0] <= l3_index[1];
        end
        l4_score[L4_N-1] <= l3_score[L3_N-1];
        l4_index[L4_N-1] <= l3_index[L3_N-1];

        if (l4_score[0] > l4_score[1])
        begin
            l5_score <= l4_score[0];
            l5_index <= l4_index[0];
        end
        else
        begin
            l5_score <= l4_score[1];
            l5_index <= l4_index[1];
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            valid_pipe <= '0;
            max_valid  <= 1'b0;
        end
        else
        begin
            valid_pipe <= {valid_pipe[LEVELS-2:0], score_valid};
            max_valid  <= valid_pipe[LEVELS-1];
        end
    end

    always_ff @(posedge clk)
    begin
        if (valid_pipe[LEVELS-1])
        begin
            max_score <= l5_score[`DISP_SCORE_W-1 -: `DISP_OUT_W];
            max_index <= l5_index;
        end
    end

endmodule

/* verilog.f */
+incdir+.
disp_types_pkg.sv
disp_regs_pkg.sv
find_max.sv
disp_result_filter.sv
disp_apb_regs.sv
disp_select_top.sv
disp_select_assert.sv
disp_select_tb.sv
